// File: rtl/cpu_pkg.sv
package cpu_pkg;

  localparam int MEM_WORDS = 16;

  typedef logic [3:0] word_t;
  typedef logic [3:0] addr_t;

  typedef enum logic [3:0] {
    OP_NOP = 4'h0,
    OP_LDA = 4'h1,  // operand word is the address
    OP_INC = 4'h2,
    OP_DEC = 4'h3,
    OP_STA = 4'h4,  // operand word is the address
    OP_BZ  = 4'h5,  // taken when acc is zero
    OP_JMP = 4'h6,
    OP_SR  = 4'h7,
    OP_LDI = 4'h9   // operand word is the data
  } opcode_t;

  // second alu operand is always one
  typedef enum logic [1:0] {
    ALU_ADD = 2'd1,
    ALU_SUB = 2'd2,
    ALU_SR  = 2'd3
  } alu_op_t;

  typedef enum logic [2:0] {
    BUS_NONE = 3'd0,
    BUS_PC   = 3'd1,
    BUS_MDR  = 3'd2,
    BUS_ACC  = 3'd3,
    BUS_ALU  = 3'd4
  } bus_src_t;

  typedef struct packed {
    addr_t addr;
    word_t data;
  } load_word_t;

  typedef struct packed {
    addr_t addr;
    word_t data;
  } store_rec_t;

  // demonstration program, counts acc down by shifting then reloads
  localparam word_t [0:MEM_WORDS-1] RESET_PROGRAM = {
    OP_LDA,   // 0  start
    4'd15,    // 1
    OP_BZ,    // 2  loop
    4'd0,     // 3
    OP_SR,    // 4
    OP_NOP,   // 5
    OP_NOP,   // 6
    OP_JMP,   // 7
    4'd2,     // 8
    4'd0,     // 9
    4'd0,     // 10
    4'd0,     // 11
    4'd0,     // 12
    4'd0,     // 13
    4'd0,     // 14
    4'd8      // 15 data
  };

endpackage

// File: rtl/word_fifo.sv
`timescale 1ns/1ps

module word_fifo #(
  parameter type payload_t = logic [7:0],
  parameter int  DEPTH     = 4
) (
  input  logic     clock,
  input  logic     reset,
  input  logic     in_valid,
  output logic     in_ready,
  input  payload_t in_data,
  output logic     out_valid,
  input  logic     out_ready,
  output payload_t out_data
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  payload_t         slots [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             push;
  logic             pop;

  // wrap for depths that are not a power of two
  function automatic logic [PTR_W-1:0] bump(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign in_ready  = (count != CNT_W'(DEPTH));  // low only when full
  assign out_valid = (count != '0);
  assign out_data  = slots[rd_ptr];
  assign push      = in_valid && in_ready;
  assign pop       = out_valid && out_ready;

  always_ff @(posedge clock) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= bump(wr_ptr);
      if (pop) rd_ptr <= bump(rd_ptr);
      count <= count + CNT_W'(push) - CNT_W'(pop);
    end
  end

  always_ff @(posedge clock) begin
    if (push) slots[wr_ptr] <= in_data;
  end

endmodule

// File: rtl/program_memory.sv
`timescale 1ns/1ps

module program_memory
  import cpu_pkg::*;
(
  input  logic       clock,
  input  logic       reset,
  input  logic       load_valid,
  output logic       load_ready,
  input  load_word_t load_item,
  input  logic       load_enable,
  input  addr_t      mar,
  input  word_t      bus,
  input  logic       mdr_listen,
  input  logic       mem_write,
  output word_t      mdr
);

  word_t      mem [MEM_WORDS];
  logic       pend_valid;  // popped load word waiting for its write
  load_word_t pend_item;

  // pending slot always drains in the same cycle it refills
  assign load_ready = load_enable;

  always_ff @(posedge clock) begin
    if (reset) begin
      pend_valid <= 1'b0;
    end else if (load_enable) begin
      pend_valid <= load_valid;
    end
  end

  always_ff @(posedge clock) begin
    if (load_enable && load_valid) pend_item <= load_item;
  end

  // one access per cycle, load writes win
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < MEM_WORDS; i++) begin
        mem[i] <= RESET_PROGRAM[i];
      end
      mdr <= '0;
    end else if (load_enable && pend_valid) begin
      mem[pend_item.addr] <= pend_item.data;
    end else if (mdr_listen) begin
      mdr <= bus;
    end else if (mem_write) begin
      mem[mar] <= mdr;
    end else begin
      mdr <= mem[mar];  // default read
    end
  end

endmodule

// File: rtl/cpu_datapath.sv
`timescale 1ns/1ps

module cpu_datapath
  import cpu_pkg::*;
(
  input  logic     clock,
  input  logic     reset,
  input  bus_src_t bus_src,
  input  logic     acc_listen,
  input  logic     pc_listen,
  input  logic     ir_listen,
  input  logic     mar_listen,
  input  logic     alu_a_listen,
  input  alu_op_t  alu_op,
  input  word_t    mdr,
  output word_t    acc,
  output word_t    ir,
  output addr_t    mar,
  output logic     acc_zero,
  output word_t    bus
);

  addr_t pc;
  word_t alu_a;
  word_t alu_result;

  // one talker at a time, selected by the sequencer
  always_comb begin
    case (bus_src)
      BUS_PC:  bus = pc;
      BUS_MDR: bus = mdr;
      BUS_ACC: bus = acc;
      BUS_ALU: bus = alu_result;
      default: bus = '0;  // bus idle
    endcase
  end

  always_comb begin
    case (alu_op)
      ALU_ADD: alu_result = alu_a + 4'd1;  // wraps at 16
      ALU_SUB: alu_result = alu_a - 4'd1;
      ALU_SR:  alu_result = alu_a >> 1;    // logical shift
      default: alu_result = alu_a;
    endcase
  end

  assign acc_zero = (acc == '0);

  always_ff @(posedge clock) begin
    if (reset) begin
      acc   <= '0;
      pc    <= '0;
      ir    <= '0;
      mar   <= '0;
      alu_a <= '0;
    end else begin
      if (acc_listen) acc <= bus;
      if (pc_listen) pc <= bus;
      if (ir_listen) ir <= bus;
      if (mar_listen) mar <= bus;
      if (alu_a_listen) alu_a <= bus;
    end
  end

endmodule

// File: rtl/cpu_sequencer.sv
`timescale 1ns/1ps

module cpu_sequencer
  import cpu_pkg::*;
(
  input  logic     clock,
  input  logic     reset,
  input  logic     run,
  input  word_t    ir,
  input  logic     acc_zero,
  input  logic     store_full,
  output bus_src_t bus_src,
  output logic     acc_listen,
  output logic     pc_listen,
  output logic     ir_listen,
  output logic     mar_listen,
  output logic     alu_a_listen,
  output logic     mdr_listen,
  output alu_op_t  alu_op,
  output logic     mem_write,
  output logic     store_push,
  output logic     load_enable,
  output logic     halted
);

  // listener masks, bit order matches the register update below
  localparam logic [5:0] LSN_ACC   = 6'b000001;
  localparam logic [5:0] LSN_PC    = 6'b000010;
  localparam logic [5:0] LSN_IR    = 6'b000100;
  localparam logic [5:0] LSN_MAR   = 6'b001000;
  localparam logic [5:0] LSN_ALU_A = 6'b010000;
  localparam logic [5:0] LSN_MDR   = 6'b100000;

  typedef struct packed {
    bus_src_t   src;
    logic [5:0] lsn;
  } xfer_t;

  logic [3:0] step;
  logic [3:0] step_next;
  opcode_t    op;
  xfer_t      xf_next;
  alu_op_t    op_next;
  logic       write_next;
  logic       push_next;
  logic       load_next;
  logic       halt_next;

  assign op = opcode_t'(ir);

  // strobes decoded in a step act on the bus during the following one
  always_comb begin
    step_next  = step + 4'd1;
    xf_next    = '{BUS_NONE, 6'b0};
    op_next    = alu_op;
    write_next = 1'b0;
    push_next  = 1'b0;
    load_next  = 1'b0;
    halt_next  = halted;
    if (halted) begin
      step_next = step;  // frozen until reset
    end else begin
      case (step)
        4'd0: begin
          if (run) begin
            xf_next = '{BUS_PC, LSN_MAR};  // fetch
          end else begin
            step_next = 4'd0;
            load_next = 1'b1;  // program load mode
          end
        end
        4'd2: xf_next = '{BUS_MDR, LSN_IR};
        4'd3: begin
          xf_next = '{BUS_PC, LSN_ALU_A};  // pc + 1
          op_next = ALU_ADD;
        end
        4'd4: xf_next = '{BUS_ALU, LSN_PC};
        4'd5: begin
          case (op)
            OP_NOP: begin
              // one idle step
            end
            OP_LDA, OP_LDI, OP_STA, OP_JMP: xf_next = '{BUS_PC, LSN_MAR};
            OP_BZ: begin
              if (acc_zero) begin
                xf_next = '{BUS_PC, LSN_MAR};  // go read the target
              end else begin
                xf_next = '{BUS_PC, LSN_ALU_A};  // skip the operand
                op_next = ALU_ADD;
              end
            end
            OP_INC, OP_DEC, OP_SR: begin
              xf_next = '{BUS_ACC, LSN_ALU_A};
              op_next = (op == OP_INC) ? ALU_ADD : (op == OP_DEC) ? ALU_SUB : ALU_SR;
            end
            default: begin
              halt_next = 1'b1;  // illegal opcode
              step_next = step;
            end
          endcase
        end
        4'd6: begin
          if (op == OP_NOP) step_next = 4'd0;
          else if (op inside {OP_INC, OP_DEC, OP_SR}) xf_next = '{BUS_ALU, LSN_ACC};
        end
        4'd7: begin
          if (op inside {OP_INC, OP_DEC, OP_SR}) step_next = 4'd0;
          else if (op inside {OP_LDA, OP_STA}) xf_next = '{BUS_MDR, LSN_MAR};
          else if (op == OP_LDI) xf_next = '{BUS_MDR, LSN_ACC};
          else if (op == OP_BZ && !acc_zero) xf_next = '{BUS_ALU, LSN_PC};
          else if (op inside {OP_BZ, OP_JMP}) xf_next = '{BUS_MDR, LSN_PC};
        end
        4'd8: begin
          if (op inside {OP_BZ, OP_JMP}) step_next = 4'd0;
        end
        4'd9: begin
          if (op == OP_LDA) begin
            xf_next = '{BUS_MDR, LSN_ACC};
          end else if (op == OP_LDI) begin
            xf_next = '{BUS_PC, LSN_ALU_A};
            op_next = ALU_ADD;
          end else if (op == OP_STA) begin
            xf_next = '{BUS_ACC, LSN_MDR};
          end
        end
        4'd10: begin
          if (op == OP_LDA) begin
            xf_next = '{BUS_PC, LSN_ALU_A};
            op_next = ALU_ADD;
          end else if (op == OP_LDI) begin
            xf_next = '{BUS_ALU, LSN_PC};
          end else if (store_full) begin
            step_next = step;  // STA waits for a free record slot
            xf_next   = '{BUS_ACC, LSN_MDR};  // keeps MDR from being read over
          end else begin
            write_next = 1'b1;
            push_next  = 1'b1;
          end
        end
        4'd11: begin
          if (op == OP_LDA) begin
            xf_next = '{BUS_ALU, LSN_PC};
          end else if (op == OP_LDI) begin
            step_next = 4'd0;
          end else begin
            xf_next = '{BUS_PC, LSN_ALU_A};
            op_next = ALU_ADD;
          end
        end
        4'd12: begin
          if (op == OP_LDA) step_next = 4'd0;
          else xf_next = '{BUS_ALU, LSN_PC};
        end
        4'd13: step_next = 4'd0;  // end of STA
        default: begin
          // memory read wait
        end
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      step        <= 4'd0;
      bus_src     <= BUS_NONE;
      alu_op      <= ALU_ADD;
      mem_write   <= 1'b0;
      store_push  <= 1'b0;
      load_enable <= 1'b0;
      halted      <= 1'b0;
      {mdr_listen, alu_a_listen, mar_listen, ir_listen, pc_listen, acc_listen} <= '0;
    end else begin
      step        <= step_next;
      bus_src     <= xf_next.src;
      alu_op      <= op_next;
      mem_write   <= write_next;
      store_push  <= push_next;
      load_enable <= load_next;
      halted      <= halt_next;
      {mdr_listen, alu_a_listen, mar_listen, ir_listen, pc_listen, acc_listen} <= xf_next.lsn;
    end
  end

endmodule

// File: rtl/cpu_top.sv
`timescale 1ns/1ps

module cpu_top
  import cpu_pkg::*;
#(
  parameter int LOAD_DEPTH  = 4,
  parameter int STORE_DEPTH = 2
) (
  input  logic  clock,
  input  logic  reset,
  input  logic  run,
  input  logic  load_valid,
  output logic  load_ready,
  input  addr_t load_addr,
  input  word_t load_data,
  output logic  store_valid,
  input  logic  store_ready,
  output addr_t store_addr,
  output word_t store_data,
  output word_t acc,
  output logic  halted
);

  load_word_t load_in;
  load_word_t load_item;
  logic       load_empty_n;
  logic       load_pop_ready;
  store_rec_t store_in;
  store_rec_t store_out;
  logic       store_in_ready;
  logic       store_full;
  logic       store_push;
  bus_src_t   bus_src;
  alu_op_t    alu_op;
  logic       acc_listen;
  logic       pc_listen;
  logic       ir_listen;
  logic       mar_listen;
  logic       alu_a_listen;
  logic       mdr_listen;
  logic       mem_write;
  logic       load_enable;
  logic       acc_zero;
  word_t      ir;
  word_t      mdr;
  word_t      bus;
  addr_t      mar;

  assign load_in    = '{addr: load_addr, data: load_data};
  assign store_in   = '{addr: mar, data: mdr};  // address and value of the write
  assign store_addr = store_out.addr;
  assign store_data = store_out.data;
  assign store_full = !store_in_ready;

  word_fifo #(.payload_t(load_word_t), .DEPTH(LOAD_DEPTH)) u_load_fifo (
    .clock(clock), .reset(reset),
    .in_valid(load_valid), .in_ready(load_ready), .in_data(load_in),
    .out_valid(load_empty_n), .out_ready(load_pop_ready), .out_data(load_item)
  );

  word_fifo #(.payload_t(store_rec_t), .DEPTH(STORE_DEPTH)) u_store_fifo (
    .clock(clock), .reset(reset),
    .in_valid(store_push), .in_ready(store_in_ready), .in_data(store_in),
    .out_valid(store_valid), .out_ready(store_ready), .out_data(store_out)
  );

  program_memory u_memory (
    .clock(clock), .reset(reset),
    .load_valid(load_empty_n), .load_ready(load_pop_ready), .load_item(load_item),
    .load_enable(load_enable), .mar(mar), .bus(bus),
    .mdr_listen(mdr_listen), .mem_write(mem_write), .mdr(mdr)
  );

  cpu_datapath u_datapath (
    .clock(clock), .reset(reset), .bus_src(bus_src),
    .acc_listen(acc_listen), .pc_listen(pc_listen), .ir_listen(ir_listen),
    .mar_listen(mar_listen), .alu_a_listen(alu_a_listen), .alu_op(alu_op),
    .mdr(mdr), .acc(acc), .ir(ir), .mar(mar), .acc_zero(acc_zero), .bus(bus)
  );

  cpu_sequencer u_sequencer (
    .clock(clock), .reset(reset), .run(run), .ir(ir),
    .acc_zero(acc_zero), .store_full(store_full), .bus_src(bus_src),
    .acc_listen(acc_listen), .pc_listen(pc_listen), .ir_listen(ir_listen),
    .mar_listen(mar_listen), .alu_a_listen(alu_a_listen), .mdr_listen(mdr_listen),
    .alu_op(alu_op), .mem_write(mem_write), .store_push(store_push),
    .load_enable(load_enable), .halted(halted)
  );

endmodule

// File: tb/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int PERIOD_NS = 40
) (
  output logic clock
);

  initial begin
    clock = 1'b0;
  end

  always #(PERIOD_NS / 2) clock = ~clock;  // 50% duty

endmodule

// File: tb/cpu_ref_model.svh
`ifndef CPU_REF_MODEL_SVH
`define CPU_REF_MODEL_SVH

localparam int MODEL_LIMIT = 64;  // programs that run longer are thrown away

// instruction mix, INC listed twice
localparam word_t OP_MENU [10] = '{OP_NOP, OP_INC, OP_DEC, OP_SR, OP_LDA,
                                   OP_LDI, OP_BZ, OP_JMP, OP_INC, OP_STA};

word_t      model_mem [MEM_WORDS];
word_t      prog_images [NUM_PROGS][MEM_WORDS];
store_rec_t exp_stores [$];
word_t      exp_acc;
logic       exp_halted;
int         exp_instrs;

// one pass per instruction, no bus steps
task automatic run_model(input int max_instrs);
  addr_t pc;
  word_t op;
  word_t arg;
  pc         = '0;
  exp_acc    = '0;
  exp_halted = 1'b0;
  exp_instrs = 0;
  exp_stores.delete();
  while (!exp_halted && exp_instrs < max_instrs) begin
    op  = model_mem[pc];
    arg = model_mem[addr_t'(pc + 4'd1)];  // operand word wraps
    exp_instrs++;
    case (op)
      OP_NOP, OP_INC, OP_DEC, OP_SR: begin
        if (op == OP_INC) exp_acc = exp_acc + 4'd1;
        else if (op == OP_DEC) exp_acc = exp_acc - 4'd1;
        else if (op == OP_SR) exp_acc = exp_acc >> 1;
        pc = pc + 4'd1;
      end
      OP_LDA: begin
        exp_acc = model_mem[arg];
        pc      = pc + 4'd2;
      end
      OP_LDI: begin
        exp_acc = arg;
        pc      = pc + 4'd2;
      end
      OP_STA: begin
        model_mem[arg] = exp_acc;
        exp_stores.push_back('{addr: arg, data: exp_acc});
        pc = pc + 4'd2;
      end
      OP_BZ:   pc = (exp_acc == '0) ? arg : pc + 4'd2;
      OP_JMP:  pc = arg;
      default: exp_halted = 1'b1;  // illegal opcode
    endcase
  end
endtask

task automatic model_program(input int idx);
  for (int i = 0; i < MEM_WORDS; i++) begin
    model_mem[i] = prog_images[idx][i];
  end
  run_model(MODEL_LIMIT);
endtask

function automatic word_t illegal_word();
  int pick;
  pick = $urandom_range(6, 0);
  return (pick == 0) ? 4'd8 : word_t'(pick + 9);  // 8 or 10..15
endfunction

// code in words 0..11, data in 12..15, jumps only go forward
task automatic gen_program(input int idx, input bit sta_heavy);
  int    p;
  int    pick;
  word_t op;
  do begin
    for (int i = 0; i < MEM_WORDS; i++) begin
      prog_images[idx][i] = (i < 12) ? illegal_word() : word_t'($urandom_range(15, 0));
    end
    p = 0;
    while (p < 10) begin
      pick = $urandom_range(9, 0);
      if (sta_heavy && pick > 4) pick = 9;
      op = OP_MENU[pick];
      prog_images[idx][p] = op;
      if (op inside {OP_LDA, OP_STA}) begin
        prog_images[idx][p + 1] = word_t'($urandom_range(15, 12));  // data area
      end else if (op == OP_LDI) begin
        prog_images[idx][p + 1] = word_t'($urandom_range(15, 0));
      end else if (op inside {OP_BZ, OP_JMP}) begin
        prog_images[idx][p + 1] = word_t'($urandom_range(11, p + 2));
      end
      p = p + ((op inside {OP_NOP, OP_INC, OP_DEC, OP_SR}) ? 1 : 2);
    end
    model_program(idx);  // word p is still illegal, so the program halts
  end while (!exp_halted);
endtask

`endif

// File: tb/tb_cpu_top.sv
`timescale 1ns/1ps

module tb_cpu_top
  import cpu_pkg::*;
();

  localparam int LOAD_DEPTH       = 4;
  localparam int STORE_DEPTH      = 2;
  localparam int NUM_LOAD_PROGS   = 6;
  localparam int NUM_BP_PROGS     = 6;
  localparam int NUM_PROGS        = 1 + NUM_LOAD_PROGS + NUM_BP_PROGS;  // 0 is directed
  localparam int RESET_CYCLES     = 8;
  localparam int DEMO_CHANGES     = 11;
  localparam int DEMO_INSTRS      = 50;  // enough for 11 acc changes
  localparam int CYCLES_PER_INSTR = 14;
  localparam int LOAD_MARGIN      = 120;
  localparam int STALL_MARGIN     = 48;
  localparam int HOLD_CYCLES      = 50;

  logic  clock;
  logic  reset;
  logic  run;
  logic  load_valid;
  logic  load_ready;
  addr_t load_addr;
  word_t load_data;
  logic  store_valid;
  logic  store_ready;
  addr_t store_addr;
  word_t store_data;
  word_t acc;
  logic  halted;

  int    errors      = 0;
  int    checks      = 0;
  int    cycle_count = 0;
  int    cycle_limit = 0;
  int    store_count = 0;
  int    store_base  = 0;
  logic  bp_enable   = 1'b0;
  int    total_instrs;
  int    total_stores;

  `include "cpu_ref_model.svh"

  tb_clock_gen #(.PERIOD_NS(40)) u_clock_gen (.clock(clock));

  cpu_top #(.LOAD_DEPTH(LOAD_DEPTH), .STORE_DEPTH(STORE_DEPTH)) u_cpu_top (
    .clock(clock), .reset(reset), .run(run),
    .load_valid(load_valid), .load_ready(load_ready),
    .load_addr(load_addr), .load_data(load_data),
    .store_valid(store_valid), .store_ready(store_ready),
    .store_addr(store_addr), .store_data(store_data),
    .acc(acc), .halted(halted)
  );

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    checks++;
    if (got !== expected) begin
      $display("FAIL %s: got 0x%0h, expected 0x%0h", name, got, expected);
      errors++;
    end
  endtask

  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit != 0 && cycle_count > cycle_limit) begin
      $display("timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("Result: FAILED");
      $finish;
    end
  end

  // store scoreboard, records are checked as they leave
  always @(posedge clock) begin
    if (!reset && store_valid && store_ready) begin
      if (store_count - store_base < exp_stores.size()) begin
        check_value("store_addr", store_addr, exp_stores[store_count - store_base].addr);
        check_value("store_data", store_data, exp_stores[store_count - store_base].data);
      end else begin
        $display("a store record to address 0x%0h came that the model did not make",
                 store_addr);
        errors++;
      end
      store_count++;
    end
  end

  initial begin
    store_ready = 1'b1;
    forever begin
      @(posedge clock);
      #2;
      store_ready = bp_enable ? ($urandom_range(15, 0) == 0) : 1'b1;  // long random stalls
    end
  end

  task automatic apply_reset(input logic run_level);
    reset      = 1'b1;
    run        = run_level;
    load_valid = 1'b0;
    repeat (RESET_CYCLES) @(posedge clock);
    #2;
    reset = 1'b0;
  endtask

  task automatic load_image(input int idx);
    int gap;
    for (int a = 0; a < MEM_WORDS; a++) begin
      gap = $urandom_range(2, 0);
      repeat (gap) begin
        @(posedge clock);
        #2;
      end
      load_valid = 1'b1;
      load_addr  = addr_t'(a);
      load_data  = prog_images[idx][a];
      @(posedge clock);
      while (!load_ready) @(posedge clock);
      #2;
      load_valid = 1'b0;
    end
  endtask

  // acc walks 8, 4, 2, 1, 0 and reloads 8
  task automatic run_demo();
    word_t prev;
    word_t expect_acc;
    int    changes;
    prev       = acc;
    expect_acc = 4'd8;
    changes    = 0;
    while (changes < DEMO_CHANGES) begin
      @(posedge clock);
      check_value("store_valid", store_valid, 1'b0);
      if (acc != prev) begin
        check_value("acc", acc, expect_acc);
        prev       = acc;
        expect_acc = (expect_acc == '0) ? 4'd8 : expect_acc >> 1;
        changes++;
      end
    end
    #2;
  endtask

  task automatic run_loaded(input int idx, input bit back_pressure, input bit hold_check);
    model_program(idx);
    apply_reset(1'b0);
    bp_enable  = back_pressure;
    store_base = store_count;
    load_image(idx);
    repeat (LOAD_DEPTH + 4) @(posedge clock);  // let the load queue drain into memory
    #2;
    run = 1'b1;
    while (!halted) @(posedge clock);
    check_value("acc", acc, exp_acc);
    if (hold_check) begin
      repeat (HOLD_CYCLES) begin
        @(posedge clock);
        check_value("halted", halted, 1'b1);
        check_value("acc", acc, exp_acc);
      end
    end
    while (store_valid) @(posedge clock);
    #2;
    check_value("store_count", store_count - store_base, exp_stores.size());
    bp_enable = 1'b0;
  endtask

  initial begin
    void'($urandom(32));
    reset      = 1'b1;
    run        = 1'b0;
    load_valid = 1'b0;
    load_addr  = '0;
    load_data  = '0;

    // LDI 5, INC, STA 14, then an illegal opcode
    for (int i = 0; i < MEM_WORDS; i++) begin
      prog_images[0][i] = '0;
    end
    prog_images[0][0] = OP_LDI;
    prog_images[0][1] = 4'd5;
    prog_images[0][2] = OP_INC;
    prog_images[0][3] = OP_STA;
    prog_images[0][4] = 4'd14;
    prog_images[0][5] = 4'hb;
    for (int i = 1; i < NUM_PROGS; i++) begin
      gen_program(i, i > NUM_LOAD_PROGS);
    end

    total_instrs = 2 * DEMO_INSTRS;
    total_stores = 0;
    for (int i = 0; i < NUM_PROGS; i++) begin
      model_program(i);
      total_instrs += ((i == 0) ? 2 : 1) * exp_instrs;  // program 0 runs twice
      total_stores += ((i == 0) ? 2 : 1) * exp_stores.size();
    end
    cycle_limit = total_instrs * CYCLES_PER_INSTR + (NUM_PROGS + 3) * LOAD_MARGIN
                + total_stores * STALL_MARGIN + 2 * HOLD_CYCLES;

    apply_reset(1'b1);
    run_demo();

    run_loaded(0, 1'b0, 1'b1);
    for (int i = 1; i <= NUM_LOAD_PROGS; i++) begin
      run_loaded(i, 1'b0, i == 1);
    end
    for (int i = NUM_LOAD_PROGS + 1; i < NUM_PROGS; i++) begin
      run_loaded(i, 1'b1, 1'b0);
    end

    // reset a halted machine and expect the demo program again
    run_loaded(0, 1'b0, 1'b0);
    repeat (5) @(posedge clock);
    #2;
    apply_reset(1'b1);
    check_value("halted", halted, 1'b0);
    check_value("acc", acc, 4'h0);
    run_demo();

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// File: src.f
+incdir+tb
rtl/cpu_pkg.sv
rtl/word_fifo.sv
rtl/program_memory.sv
rtl/cpu_datapath.sv
rtl/cpu_sequencer.sv
rtl/cpu_top.sv
tb/tb_clock_gen.sv
tb/tb_cpu_top.sv

// File: run_sim.sh
#!/bin/sh
# build with Verilator, run, and pass only if the pass line shows up
cd "$(dirname "$0")" \
  && verilator --binary --timing -Wno-fatal --top-module tb_cpu_top -f src.f -o tb_cpu_top \
  && ./obj_dir/tb_cpu_top | awk '{ print } /^Result: PASSED$/ { ok = 1 } END { exit !ok }' \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
